// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_load_store_unit
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
hdl/lsu_pkg.sv
hdl/lsu_queue.sv
hdl/lsu_disambig.sv
hdl/lsu_l1d_port.sv
hdl/lsu_retire.sv
hdl/load_store_unit.sv
test/l1d_model.sv
test/tb_load_store_unit.sv

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  // Core instruction channel
  input  logic                   instr_valid,
  input  lsu_pkg::lsu_instr_t    instr,
  output logic                   instr_ready,
  // Core data channel
  input  logic                   data_valid,
  input  lsu_pkg::lsu_data_t     data,
  output logic                   data_ready,
  // Completion to the core
  output logic                   cpl_valid,
  output lsu_pkg::lsu_cpl_t      cpl,
  // L1D
  output logic                   l1d_req_valid,
  output lsu_pkg::lsu_l1d_req_t  l1d_req,
  input  logic                   l1d_req_ready,
  input  logic                   l1d_resp_valid,
  input  lsu_pkg::lsu_l1d_resp_t l1d_resp
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  lsu_entry_t [QUEUE_DEPTH-1:0] entries;
  logic [IDX_W-1:0]             head;
  lsu_act_e                     act;
  logic [IDX_W-1:0]             act_idx;
  logic [DATA_W-1:0]            fwd_value;
  logic                         req_valid;
  lsu_l1d_req_t                 req;
  logic                         req_ready;
  logic                         resp_valid;
  lsu_l1d_resp_t                resp;
  logic                         free_valid;
  logic [IDX_W-1:0]             free_idx;

  lsu_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_queue (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .instr_valid(instr_valid),
    .instr      (instr),
    .instr_ready(instr_ready),
    .data_valid (data_valid),
    .data       (data),
    .data_ready (data_ready),
    .entries    (entries),
    .head       (head),
    .act        (act),
    .act_idx    (act_idx),
    .fwd_value  (fwd_value),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .free_valid (free_valid),
    .free_idx   (free_idx)
  );

  // Ordering decision, purely combinational
  lsu_disambig #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_disambig (
    .entries  (entries),
    .head     (head),
    .act      (act),
    .act_idx  (act_idx),
    .fwd_value(fwd_value)
  );

  lsu_l1d_port u_l1d_port (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .l1d_req_valid (l1d_req_valid),
    .l1d_req       (l1d_req),
    .l1d_req_ready (l1d_req_ready),
    .l1d_resp_valid(l1d_resp_valid),
    .l1d_resp      (l1d_resp)
  );

  lsu_retire #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_retire (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .entries   (entries),
    .head      (head),
    .free_valid(free_valid),
    .free_idx  (free_idx),
    .cpl_valid (cpl_valid),
    .cpl       (cpl)
  );

endmodule

// ==== hdl/lsu_disambig.sv ====
`timescale 1ns/1ps

module lsu_disambig #(
  parameter int QUEUE_DEPTH = 16
) (
  input  lsu_pkg::lsu_entry_t [QUEUE_DEPTH-1:0] entries,
  input  logic [$clog2(QUEUE_DEPTH)-1:0]    head,
  output lsu_pkg::lsu_act_e                 act,
  output logic [$clog2(QUEUE_DEPTH)-1:0]    act_idx,
  output logic [lsu_pkg::DATA_W-1:0]        fwd_value
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  // ----------------------------------------------------------------------
  // Oldest actionable slot in age order from the head
  // ----------------------------------------------------------------------
  always_comb begin
    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  older;
    logic              blocked;
    logic              hit;
    logic [DATA_W-1:0] hit_value;

    act       = ACT_NONE;
    act_idx   = '0;
    fwd_value = '0;
    for (int k = 0; k < QUEUE_DEPTH; k++) begin
      idx       = head + IDX_W'(k);
      blocked   = 1'b0;
      hit       = 1'b0;
      hit_value = '0;
      // Look at every older store
      for (int m = 0; m < k; m++) begin
        older = head + IDX_W'(m);
        if (entries[older].valid && entries[older].is_store) begin
          if (!entries[older].resolved) begin
            // Unknown address makes the load wait
            blocked = 1'b1;
          end else if (!entries[older].done &&
                       entries[older].addr == entries[idx].addr) begin
            // Written stores hold zero and sit in the L1D already
            // Later match overrides so the youngest one wins
            hit       = 1'b1;
            hit_value = entries[older].value;
          end
        end
      end

      if (act == ACT_NONE && entries[idx].valid && entries[idx].resolved &&
          !entries[idx].issued && !entries[idx].done) begin
        if (entries[idx].is_store) begin
          // Stores write the L1D in program order from the head
          if (k == 0) begin
            act     = ACT_MEMORY;
            act_idx = idx;
          end
        end else if (!blocked) begin
          act_idx = idx;
          if (hit) begin
            act       = ACT_FORWARD;
            fwd_value = hit_value;
          end else begin
            act = ACT_MEMORY;
          end
        end
      end
    end
  end

endmodule

// ==== hdl/lsu_l1d_port.sv ====
`timescale 1ns/1ps

module lsu_l1d_port (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  logic                   req_valid,
  input  lsu_pkg::lsu_l1d_req_t  req,
  output logic                   req_ready,
  output logic                   resp_valid,
  output lsu_pkg::lsu_l1d_resp_t resp,
  output logic                   l1d_req_valid,
  output lsu_pkg::lsu_l1d_req_t  l1d_req,
  input  logic                   l1d_req_ready,
  input  logic                   l1d_resp_valid,
  input  lsu_pkg::lsu_l1d_resp_t l1d_resp
);

  // One access outstanding at a time
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RESP
  } state_e;

  state_e state;
  state_e state_next;

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_valid) begin
          state_next = REQUEST;
        end
      end
      REQUEST: begin
        // Hold until the L1D takes it
        if (l1d_req_ready) begin
          state_next = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        if (l1d_resp_valid) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Request latched on acceptance from the queue
  always_ff @(posedge clk_in) begin
    if (req_valid && req_ready) begin
      l1d_req <= req;
    end
  end

  assign req_ready     = (state == IDLE);
  assign l1d_req_valid = (state == REQUEST);

  // Response passed back in the same cycle
  assign resp_valid = (state == WAIT_RESP) && l1d_resp_valid;
  always_comb begin
    resp.tag      = l1d_resp.tag;
    resp.is_write = l1d_resp.is_write;
    // Writes return zero
    resp.value    = l1d_resp.is_write ? '0 : l1d_resp.value;
  end

  // Request held steady under L1D back-pressure
  a_req_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_req_valid && !l1d_req_ready |=> l1d_req_valid && $stable(l1d_req));

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

  // ----------------------------------------------------------------------
  // Widths shared by the whole load-store unit
  // ----------------------------------------------------------------------

  // Address and value width
  localparam int DATA_W = 64;
  // Instruction tag width
  localparam int TAG_W = 8;

  // Allocation from the core, in program order
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             is_store;
  } lsu_instr_t;

  // Address and store data, arriving later in any order
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] value;
  } lsu_data_t;

  // One ring slot
  typedef struct packed {
    logic              valid;
    // Address (and store data) present
    logic              resolved;
    logic              is_store;
    // Sent to the L1D with result pending
    logic              issued;
    // Value final and waiting for retire
    logic              done;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] value;
  } lsu_entry_t;

  // Disambiguator decision for the selected slot
  typedef enum logic [1:0] {
    ACT_NONE,
    ACT_FORWARD,
    ACT_MEMORY
  } lsu_act_e;

  // ----------------------------------------------------------------------
  // L1D and completion payloads
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic              we;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] value;
    logic [TAG_W-1:0]  tag;
  } lsu_l1d_req_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
    logic              is_write;
  } lsu_l1d_resp_t;

  // Stores complete with value zero
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
  } lsu_cpl_t;

endpackage

// ==== hdl/lsu_queue.sv ====
`timescale 1ns/1ps

module lsu_queue #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                              clk_in,
  input  logic                              rst_N_in,
  input  logic                              instr_valid,
  input  lsu_pkg::lsu_instr_t               instr,
  output logic                              instr_ready,
  input  logic                              data_valid,
  input  lsu_pkg::lsu_data_t                data,
  output logic                              data_ready,
  output lsu_pkg::lsu_entry_t [QUEUE_DEPTH-1:0] entries,
  output logic [$clog2(QUEUE_DEPTH)-1:0]    head,
  input  lsu_pkg::lsu_act_e                 act,
  input  logic [$clog2(QUEUE_DEPTH)-1:0]    act_idx,
  input  logic [lsu_pkg::DATA_W-1:0]        fwd_value,
  output logic                              req_valid,
  output lsu_pkg::lsu_l1d_req_t             req,
  input  logic                              req_ready,
  input  logic                              resp_valid,
  input  lsu_pkg::lsu_l1d_resp_t            resp,
  input  logic                              free_valid,
  input  logic [$clog2(QUEUE_DEPTH)-1:0]    free_idx
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  // Slot state flags
  logic [QUEUE_DEPTH-1:0] valid_q;
  logic [QUEUE_DEPTH-1:0] resolved_q;
  logic [QUEUE_DEPTH-1:0] issued_q;
  logic [QUEUE_DEPTH-1:0] done_q;
  // Slot payload
  logic [QUEUE_DEPTH-1:0] store_q;
  logic [TAG_W-1:0]       tag_q   [QUEUE_DEPTH];
  logic [DATA_W-1:0]      addr_q  [QUEUE_DEPTH];
  logic [DATA_W-1:0]      value_q [QUEUE_DEPTH];

  logic [IDX_W-1:0] tail;
  logic [IDX_W:0]   count;
  logic [IDX_W:0]   count_next;
  logic             alloc;
  logic             pop;
  logic             data_hit;
  logic [IDX_W-1:0] data_idx;
  logic             data_fire;
  logic             resp_hit;
  logic [IDX_W-1:0] resp_idx;
  logic             mem_fire;

  // ----------------------------------------------------------------------
  // Handshakes and tag lookup
  // ----------------------------------------------------------------------
  assign alloc      = instr_valid && instr_ready;
  // Head slot already freed by retire
  assign pop        = (count != '0) && !valid_q[head];
  assign count_next = count + (IDX_W+1)'(alloc) - (IDX_W+1)'(pop);
  assign data_ready = |(valid_q & ~resolved_q);
  assign data_fire  = data_valid && data_ready && data_hit;
  assign mem_fire   = (act == ACT_MEMORY) && req_ready;

  always_comb begin
    data_hit = 1'b0;
    data_idx = '0;
    resp_hit = 1'b0;
    resp_idx = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      // Unresolved slot waiting for this tag
      if (valid_q[i] && !resolved_q[i] && tag_q[i] == data.tag) begin
        data_hit = 1'b1;
        data_idx = IDX_W'(i);
      end
      // Outstanding access of the same kind
      if (valid_q[i] && issued_q[i] && !done_q[i] && tag_q[i] == resp.tag &&
          store_q[i] == resp.is_write) begin
        resp_hit = 1'b1;
        resp_idx = IDX_W'(i);
      end
    end
  end

  // Selected memory action goes straight to the port
  assign req_valid = (act == ACT_MEMORY);
  always_comb begin
    req.we    = store_q[act_idx];
    req.addr  = addr_q[act_idx];
    req.value = value_q[act_idx];
    req.tag   = tag_q[act_idx];
  end

  always_comb begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      entries[i].valid    = valid_q[i];
      entries[i].resolved = resolved_q[i];
      entries[i].is_store = store_q[i];
      entries[i].issued   = issued_q[i];
      entries[i].done     = done_q[i];
      entries[i].tag      = tag_q[i];
      entries[i].addr     = addr_q[i];
      entries[i].value    = value_q[i];
    end
  end

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      valid_q     <= '0;
      resolved_q  <= '0;
      issued_q    <= '0;
      done_q      <= '0;
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      instr_ready <= 1'b0;
    end else begin
      count       <= count_next;
      // Full flag tracks next occupancy
      instr_ready <= (count_next != (IDX_W+1)'(QUEUE_DEPTH));
      if (pop) begin
        head <= head + IDX_W'(1);
      end
      if (alloc) begin
        valid_q[tail]    <= 1'b1;
        resolved_q[tail] <= 1'b0;
        issued_q[tail]   <= 1'b0;
        done_q[tail]     <= 1'b0;
        tail             <= tail + IDX_W'(1);
      end
      if (data_fire) begin
        resolved_q[data_idx] <= 1'b1;
      end
      if (act == ACT_FORWARD) begin
        done_q[act_idx] <= 1'b1;
      end
      if (mem_fire) begin
        issued_q[act_idx] <= 1'b1;
      end
      if (resp_valid && resp_hit) begin
        done_q[resp_idx] <= 1'b1;
      end
      // Retired slot becomes empty
      if (free_valid) begin
        valid_q[free_idx]    <= 1'b0;
        resolved_q[free_idx] <= 1'b0;
        issued_q[free_idx]   <= 1'b0;
        done_q[free_idx]     <= 1'b0;
      end
    end
  end

  // Payload updates
  always_ff @(posedge clk_in) begin
    if (alloc) begin
      store_q[tail] <= instr.is_store;
      tag_q[tail]   <= instr.tag;
    end
    if (data_fire) begin
      addr_q[data_idx]  <= data.addr;
      value_q[data_idx] <= data.value;
    end
    if (act == ACT_FORWARD) begin
      value_q[act_idx] <= fwd_value;
    end
    if (resp_valid && resp_hit) begin
      value_q[resp_idx] <= resp.value;
    end
  end

  // Tail slot must have been drained by retire and head advance
  a_alloc_not_full: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    alloc |-> (count < (IDX_W+1)'(QUEUE_DEPTH)) && !valid_q[tail]);

  // Every L1D response belongs to a slot issued earlier
  a_resp_issued: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    resp_valid |-> resp_hit);

endmodule

// ==== hdl/lsu_retire.sv ====
`timescale 1ns/1ps

module lsu_retire #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                              clk_in,
  input  logic                              rst_N_in,
  input  lsu_pkg::lsu_entry_t [QUEUE_DEPTH-1:0] entries,
  input  logic [$clog2(QUEUE_DEPTH)-1:0]    head,
  output logic                              free_valid,
  output logic [$clog2(QUEUE_DEPTH)-1:0]    free_idx,
  output logic                              cpl_valid,
  output lsu_pkg::lsu_cpl_t                 cpl
);

  localparam int IDX_W = $clog2(QUEUE_DEPTH);

  // Oldest finished slot, one per cycle
  always_comb begin
    logic [IDX_W-1:0] idx;

    free_valid = 1'b0;
    free_idx   = '0;
    for (int k = 0; k < QUEUE_DEPTH; k++) begin
      idx = head + IDX_W'(k);
      if (!free_valid && entries[idx].valid && entries[idx].done) begin
        free_valid = 1'b1;
        free_idx   = idx;
      end
    end
  end

  // Completion pulse, slot freed on the same edge
  always_ff @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      cpl_valid <= 1'b0;
    end else begin
      cpl_valid <= free_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (free_valid) begin
      cpl.tag   <= entries[free_idx].tag;
      cpl.value <= entries[free_idx].value;
    end
  end

endmodule

// ==== test/l1d_model.sv ====
`timescale 1ns/1ps

module l1d_model #(
  parameter logic [63:0] FILL_KEY = 64'h0
) (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  logic                   req_valid,
  input  lsu_pkg::lsu_l1d_req_t  req,
  output logic                   req_ready = 1'b0,
  output logic                   resp_valid = 1'b0,
  output lsu_pkg::lsu_l1d_resp_t resp = '0,
  output int                     reads = 0,
  output int                     writes = 0
);
  import lsu_pkg::*;

  // Word array, indexed by address bits 10:3
  logic [63:0]   mem [256];
  integer        seed = 32'h29b9;
  logic          take;
  lsu_l1d_req_t  taken;
  lsu_l1d_resp_t pending;
  logic          busy = 1'b0;
  int            delay = 0;

  // Request accepted on this edge
  always @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      take <= 1'b0;
    end else begin
      take  <= req_valid && req_ready;
      taken <= req;
    end
  end

  // Outputs change on the falling edge only
  always @(negedge clk_in) begin
    resp_valid = 1'b0;
    if (!rst_N_in) begin
      req_ready = 1'b0;
      busy      = 1'b0;
      // Preload, value is the word address XOR a key
      for (int i = 0; i < 256; i++) begin
        mem[i] = (64'(i) << 3) ^ FILL_KEY;
      end
    end else if (take) begin
      pending.tag      = taken.tag;
      pending.is_write = taken.we;
      if (taken.we) begin
        mem[taken.addr[10:3]] = taken.value;
        pending.value         = '0;
        writes++;
      end else begin
        pending.value = mem[taken.addr[10:3]];
        reads++;
      end
      busy      = 1'b1;
      delay     = int'($unsigned($random(seed)) % 4);
      req_ready = 1'b0;
    end else if (busy) begin
      // Response after a random wait
      if (delay == 0) begin
        resp_valid = 1'b1;
        resp       = pending;
        busy       = 1'b0;
      end else begin
        delay--;
      end
    end else begin
      // Ready about two thirds of the time
      req_ready = ($unsigned($random(seed)) % 3) != 0;
    end
  end

endmodule

// ==== test/tb_load_store_unit.sv ====
`timescale 1ns/1ps

module tb_load_store_unit;
  import lsu_pkg::*;

  localparam int          DEPTH    = 8;
  localparam int          LIMIT    = 2000;
  localparam logic [63:0] FILL_KEY = 64'h5a5a_c3c3_0f0f_9696;
  // Step kinds
  localparam logic [2:0]  K_ALLOC  = 3'd0;
  localparam logic [2:0]  K_DATA   = 3'd1;
  localparam logic [2:0]  K_SYNC   = 3'd2;
  localparam logic [2:0]  K_FULL   = 3'd3;
  localparam logic [2:0]  K_REOPEN = 3'd4;

  typedef struct packed {
    logic [2:0]  kind;
    logic [7:0]  tag;
    logic        is_store;
    logic [63:0] addr;
    logic [63:0] value;
    // Completion value, or read count delta for a sync step
    logic [63:0] exp;
  } step_t;

  logic          clk_in;
  logic          rst_N_in;
  logic          instr_valid;
  lsu_instr_t    instr;
  logic          instr_ready;
  logic          data_valid;
  lsu_data_t     data;
  logic          data_ready;
  logic          cpl_valid;
  lsu_cpl_t      cpl;
  logic          l1d_req_valid;
  lsu_l1d_req_t  l1d_req;
  logic          l1d_req_ready;
  logic          l1d_resp_valid;
  lsu_l1d_resp_t l1d_resp;
  int            reads;
  int            writes;

  step_t         steps[$];
  logic [63:0]   got_value [256];
  logic          got_flag  [256];
  int            n_cpl = 0;
  int            dup_errors = 0;
  int            errors = 0;
  int            checks = 0;
  int            n_alloc = 0;
  logic          abort = 1'b0;

  load_store_unit #(.QUEUE_DEPTH(DEPTH)) UUT (
    .clk_in(clk_in), .rst_N_in(rst_N_in),
    .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
    .data_valid(data_valid), .data(data), .data_ready(data_ready),
    .cpl_valid(cpl_valid), .cpl(cpl),
    .l1d_req_valid(l1d_req_valid), .l1d_req(l1d_req), .l1d_req_ready(l1d_req_ready),
    .l1d_resp_valid(l1d_resp_valid), .l1d_resp(l1d_resp)
  );

  l1d_model #(.FILL_KEY(FILL_KEY)) L1D (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .req_valid(l1d_req_valid), .req(l1d_req),
    .req_ready(l1d_req_ready), .resp_valid(l1d_resp_valid), .resp(l1d_resp),
    .reads(reads), .writes(writes)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // Completion collector, sampled mid-cycle
  always @(negedge clk_in) begin
    if (rst_N_in && cpl_valid) begin
      if (got_flag[cpl.tag]) begin
        $display("Tag %h completed twice", cpl.tag);
        dup_errors++;
      end
      got_flag[cpl.tag]  = 1'b1;
      got_value[cpl.tag] = cpl.value;
      n_cpl++;
    end
  end

  // ----------------------------------------------------------------------
  // Table builders
  // ----------------------------------------------------------------------
  task automatic add_alloc(input logic [7:0] tag, input logic st, input logic [63:0] exp);
    steps.push_back({K_ALLOC, tag, st, 64'h0, 64'h0, exp});
  endtask

  task automatic add_data(input logic [7:0] tag, input logic [63:0] addr,
                          input logic [63:0] value);
    steps.push_back({K_DATA, tag, 1'b0, addr, value, 64'h0});
  endtask

  task automatic add_mark(input logic [2:0] kind, input logic [63:0] exp);
    steps.push_back({kind, 8'h0, 1'b0, 64'h0, 64'h0, exp});
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    abort = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int          n;
    int          phase_start;
    int          reads_base;
    step_t       s;

    rst_N_in    = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    data_valid  = 1'b0;
    data        = '0;
    phase_start = 0;
    reads_base  = 0;
    for (int t = 0; t < 256; t++) begin
      got_flag[t]  = 1'b0;
      got_value[t] = '0;
    end

    // Single load from the preloaded memory
    add_alloc(8'h01, 1'b0, 64'h100 ^ FILL_KEY);
    add_data(8'h01, 64'h100, 64'h0);
    add_mark(K_SYNC, 64'd1);
    // Store then load, both resolved in order
    add_alloc(8'h02, 1'b1, 64'h0);
    add_alloc(8'h03, 1'b0, 64'h1111_2222_3333_4444);
    add_data(8'h02, 64'h108, 64'h1111_2222_3333_4444);
    add_data(8'h03, 64'h108, 64'h0);
    add_mark(K_SYNC, 64'd0);
    // Load resolved before its older store
    add_alloc(8'h04, 1'b1, 64'h0);
    add_alloc(8'h05, 1'b0, 64'hdead_beef_0bad_f00d);
    add_data(8'h05, 64'h110, 64'h0);
    add_data(8'h04, 64'h110, 64'hdead_beef_0bad_f00d);
    add_mark(K_SYNC, 64'd0);
    // Store ordering, data in reverse
    add_alloc(8'h06, 1'b1, 64'h0);
    add_alloc(8'h07, 1'b1, 64'h0);
    add_alloc(8'h08, 1'b1, 64'h0);
    add_data(8'h08, 64'h120, 64'h8888);
    add_data(8'h07, 64'h118, 64'h7777);
    add_data(8'h06, 64'h118, 64'h6666);
    add_mark(K_SYNC, 64'd0);
    // Fill the queue, then drain from the head
    for (int t = 0; t < DEPTH; t++) begin
      add_alloc(8'(16 + t), 1'b0, (64'h200 + 64'(t * 8)) ^ FILL_KEY);
    end
    add_mark(K_FULL, 64'h0);
    add_data(8'd16, 64'h200, 64'h0);
    add_mark(K_REOPEN, 64'h0);
    for (int t = 1; t < DEPTH; t++) begin
      add_data(8'(16 + t), 64'h200 + 64'(t * 8), 64'h0);
    end
    add_mark(K_SYNC, 64'(DEPTH));

    repeat (16) @(negedge clk_in);
    rst_N_in = 1'b1;
    @(negedge clk_in);
    @(negedge clk_in);
    check_value("instr_ready", 64'(instr_ready), 64'h1);
    check_value("data_ready", 64'(data_ready), 64'h0);
    check_value("cpl_valid", 64'(cpl_valid), 64'h0);
    check_value("l1d_req_valid", 64'(l1d_req_valid), 64'h0);

    for (int i = 0; i < steps.size() && !abort; i++) begin
      s = steps[i];
      n = 0;
      case (s.kind)
        K_ALLOC: begin
          while (!instr_ready && n < LIMIT) begin
            @(negedge clk_in);
            n++;
          end
          if (n >= LIMIT) begin
            note_timeout("instr_ready");
          end else begin
            instr_valid    = 1'b1;
            instr.tag      = s.tag;
            instr.is_store = s.is_store;
            n_alloc++;
            @(negedge clk_in);
            instr_valid = 1'b0;
          end
        end
        K_DATA: begin
          while (!data_ready && n < LIMIT) begin
            @(negedge clk_in);
            n++;
          end
          if (n >= LIMIT) begin
            note_timeout("data_ready");
          end else begin
            data_valid = 1'b1;
            data.tag   = s.tag;
            data.addr  = s.addr;
            data.value = s.value;
            @(negedge clk_in);
            data_valid = 1'b0;
          end
        end
        K_FULL: begin
          check_value("instr_ready", 64'(instr_ready), 64'h0);
        end
        K_REOPEN: begin
          while (!instr_ready && n < LIMIT) begin
            @(negedge clk_in);
            n++;
          end
          if (n >= LIMIT) begin
            note_timeout("instr_ready after a retire");
          end
        end
        default: begin
          // All allocated operations must complete
          while (n_cpl < n_alloc && n < LIMIT) begin
            @(negedge clk_in);
            n++;
          end
          if (n >= LIMIT) begin
            note_timeout("completions");
          end else begin
            for (int j = phase_start; j < i; j++) begin
              if (steps[j].kind == K_ALLOC) begin
                checks++;
                if (!got_flag[steps[j].tag]) begin
                  $display("No completion for tag %h", steps[j].tag);
                  errors++;
                end
                check_value($sformatf("cpl.value tag %h", steps[j].tag),
                            got_value[steps[j].tag], steps[j].exp);
              end
            end
            check_value("l1d reads", 64'(reads - reads_base), s.exp);
          end
          phase_start = i + 1;
          reads_base  = reads;
        end
      endcase
    end

    // Memory holds the last store in program order
    check_value("mem[108]", L1D.mem[8'h21], 64'h1111_2222_3333_4444);
    check_value("mem[110]", L1D.mem[8'h22], 64'hdead_beef_0bad_f00d);
    check_value("mem[118]", L1D.mem[8'h23], 64'h7777);
    check_value("mem[120]", L1D.mem[8'h24], 64'h8888);
    check_value("l1d writes", 64'(writes), 64'd5);

    $display("checks=%0d errors=%0d duplicates=%0d", checks, errors, dup_errors);
    if (errors == 0 && dup_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
